// ==== rtl/histConfigPkg.sv ====
`default_nettype none

package histConfigPkg;

    // coarse timestamp from the TDC front end
    localparam int dataWidth = 10;

    // bin index is taken from the upper timestamp bits
    localparam int binAddrWidth = 6;
    localparam int binNum = 64;

    // per-bin counter, saturating at all ones
    localparam int countWidth = 4;

    // timestamps accepted per pixel before the scan
    // chosen above the counter range so a single bin can saturate
    localparam int acqNum = 24;

    // pixels sharing this engine, one after the other
    localparam int pixelNum = 4;
    localparam int pixelWidth = 2;

endpackage

`default_nettype wire

// ==== rtl/histCtrlPkg.sv ====
`default_nettype none

package histCtrlPkg;

    // controller phases
    typedef enum logic [2:0] {
        stClear,
        stAccum,
        stDrain,
        stScan,
        stReport
    } histState;

    // read request to data on the bin memory read port
    localparam int scanLatency = 1;

    // cycles spent letting the last increment land in memory
    localparam int drainCycles = 2;

endpackage

`default_nettype wire

// ==== rtl/binRam.sv ====
`timescale 1ns/1ns
`default_nettype none

module binRam
    import histConfigPkg::*;
(
    input  logic                    clk,
    // write port
    input  logic [binAddrWidth-1:0] waddr,
    input  logic                    wEnable,
    input  logic [countWidth-1:0]   newCounts,
    // read port
    input  logic [binAddrWidth-1:0] raddr,
    input  logic                    rEnable,
    output logic [countWidth-1:0]   counts
);

    // one counter per bin
    logic [countWidth-1:0] mem [binNum];

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // registered read, data one cycle after rEnable
    // same-address write in the same cycle gives the old word
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/histFsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module histFsm
    import histConfigPkg::*, histCtrlPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    // timestamp input
    input  logic [dataWidth-1:0]    data,
    input  logic                    dataValid,
    output logic                    wrEn,
    // bin memory
    input  logic [countWidth-1:0]   counts,
    output logic [binAddrWidth-1:0] raddr,
    output logic                    rEnable,
    output logic [binAddrWidth-1:0] waddr,
    output logic                    wEnable,
    output logic [countWidth-1:0]   newCounts,
    // scan towards the peak finder
    output logic                    scanValid,
    output logic [binAddrWidth-1:0] scanBin,
    output logic                    scanLast,
    output logic [pixelWidth-1:0]   pixel
);

    histState state;

    // shared by clear, drain and scan, one bit wider to cover the scan tail
    logic [binAddrWidth:0]         binCnt;
    logic [$clog2(acqNum)-1:0]     acqCnt;

    // increment pipeline, stage 2 and forwarding
    logic                          s2Valid;
    logic [binAddrWidth-1:0]       s2Bin;
    logic                          fwdHit;
    logic [countWidth-1:0]         fwdCount;

    logic                          accept;
    logic                          scanRead;
    logic [binAddrWidth-1:0]       readBin;
    logic [binAddrWidth:0]         scanIdx;
    logic [countWidth-1:0]         baseCount;
    logic [countWidth-1:0]         incCount;

    assign wrEn = (state == stAccum);
    assign accept = wrEn && dataValid;

    // bin select from upper timestamp bits
    assign readBin = data[dataWidth-1 -: binAddrWidth];

    // scan reads bins 0..binNum-1, data trails by scanLatency
    assign scanRead = (state == stScan) && (binCnt < (binAddrWidth + 1)'(binNum));
    assign scanIdx = binCnt - (binAddrWidth + 1)'(scanLatency);
    assign scanValid = (state == stScan) && (binCnt >= (binAddrWidth + 1)'(scanLatency));
    assign scanBin = scanIdx[binAddrWidth-1:0];
    assign scanLast = scanValid && (scanIdx == (binAddrWidth + 1)'(binNum - 1));

    // stale memory word replaced when the previous write hit the same bin
    assign baseCount = fwdHit ? fwdCount : counts;
    assign incCount = (baseCount == {countWidth{1'b1}}) ? baseCount : baseCount + 1'b1;

    always_comb begin
        rEnable = accept || scanRead;
        raddr = scanRead ? binCnt[binAddrWidth-1:0] : readBin;

        if (state == stClear) begin
            // zero fill after reset
            wEnable = 1'b1;
            waddr = binCnt[binAddrWidth-1:0];
            newCounts = '0;
        end else if (s2Valid) begin
            // saturating increment
            wEnable = 1'b1;
            waddr = s2Bin;
            newCounts = incCount;
        end else begin
            // zero each bin right after the scan has read it
            wEnable = scanValid;
            waddr = scanBin;
            newCounts = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stClear;
            binCnt <= '0;
            acqCnt <= '0;
            pixel <= '0;
            s2Valid <= 1'b0;
            fwdHit <= 1'b0;
        end else begin
            s2Valid <= accept;
            // next stage 2 reads the bin being written now
            fwdHit <= accept && s2Valid && (s2Bin == readBin);

            case (state)
                stClear: begin
                    if (binCnt == (binAddrWidth + 1)'(binNum - 1)) begin
                        binCnt <= '0;
                        state <= stAccum;
                    end else begin
                        binCnt <= binCnt + 1'b1;
                    end
                end
                stAccum: begin
                    if (accept) begin
                        if (acqCnt == $bits(acqCnt)'(acqNum - 1)) begin
                            acqCnt <= '0;
                            state <= stDrain;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end
                end
                stDrain: begin
                    if (binCnt == (binAddrWidth + 1)'(drainCycles - 1)) begin
                        binCnt <= '0;
                        state <= stScan;
                    end else begin
                        binCnt <= binCnt + 1'b1;
                    end
                end
                stScan: begin
                    // last read issued, pixel moves on
                    if (binCnt == (binAddrWidth + 1)'(binNum - 1)) begin
                        if (pixel == pixelWidth'(pixelNum - 1)) begin
                            pixel <= '0;
                        end else begin
                            pixel <= pixel + 1'b1;
                        end
                    end
                    if (binCnt == (binAddrWidth + 1)'(binNum - 1 + scanLatency)) begin
                        binCnt <= '0;
                        state <= stReport;
                    end else begin
                        binCnt <= binCnt + 1'b1;
                    end
                end
                stReport: begin
                    state <= stAccum;
                end
                default: begin
                    state <= stClear;
                end
            endcase
        end
    end

    // stage 2 payload
    always_ff @(posedge clk) begin
        s2Bin <= readBin;
        fwdCount <= incCount;
    end

endmodule

`default_nettype wire

// ==== rtl/peakFinder.sv ====
`timescale 1ns/1ns
`default_nettype none

module peakFinder
    import histConfigPkg::*, histCtrlPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    // scan stream, counts straight from the bin memory
    input  logic                    scanValid,
    input  logic [binAddrWidth-1:0] scanBin,
    input  logic                    scanLast,
    input  logic [pixelWidth-1:0]   pixel,
    input  logic [countWidth-1:0]   counts,
    // per-pixel result
    output logic                    peakValid,
    output logic [pixelWidth-1:0]   peakPixel,
    output logic [binAddrWidth-1:0] peakBin,
    output logic [countWidth-1:0]   peakCount
);

    // pixel index lined up with the memory read latency
    logic [pixelWidth-1:0]   pixelPipe [scanLatency];

    // running best of the current scan
    logic [binAddrWidth-1:0] bestBin;
    logic [countWidth-1:0]   bestCount;
    logic                    better;

    // strictly larger only, lowest bin wins a tie
    assign better = counts > bestCount;

    always_ff @(posedge clk) begin
        pixelPipe[0] <= pixel;
        for (int i = 1; i < scanLatency; i++) begin
            pixelPipe[i] <= pixelPipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bestBin <= '0;
            bestCount <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanValid && scanLast;
            if (scanValid && scanLast) begin
                // back to bin 0 / count 0 for the next pixel
                bestBin <= '0;
                bestCount <= '0;
            end else if (scanValid && better) begin
                bestBin <= scanBin;
                bestCount <= counts;
            end
        end
    end

    // result held until the next pulse
    // last bin still takes part in the compare
    always_ff @(posedge clk) begin
        if (scanValid && scanLast) begin
            peakPixel <= pixelPipe[scanLatency-1];
            peakBin <= better ? scanBin : bestBin;
            peakCount <= better ? counts : bestCount;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/histTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module histTop
    import histConfigPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [dataWidth-1:0]    data,
    input  logic                    dataValid,
    output logic                    wrEn,
    output logic                    peakValid,
    output logic [pixelWidth-1:0]   peakPixel,
    output logic [binAddrWidth-1:0] peakBin,
    output logic [countWidth-1:0]   peakCount
);

    // memory ports
    logic [binAddrWidth-1:0] raddr;
    logic [binAddrWidth-1:0] waddr;
    logic                    rEnable;
    logic                    wEnable;
    logic [countWidth-1:0]   newCounts;
    logic [countWidth-1:0]   counts;

    // scan stream
    logic                    scanValid;
    logic [binAddrWidth-1:0] scanBin;
    logic                    scanLast;
    logic [pixelWidth-1:0]   pixel;

    histFsm fsm_i (
        .clk       (clk),
        .rstN      (rstN),
        .data      (data),
        .dataValid (dataValid),
        .wrEn      (wrEn),
        .counts    (counts),
        .raddr     (raddr),
        .rEnable   (rEnable),
        .waddr     (waddr),
        .wEnable   (wEnable),
        .newCounts (newCounts),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanLast  (scanLast),
        .pixel     (pixel)
    );

    binRam binRam_i (
        .clk       (clk),
        .waddr     (waddr),
        .wEnable   (wEnable),
        .newCounts (newCounts),
        .raddr     (raddr),
        .rEnable   (rEnable),
        .counts    (counts)
    );

    peakFinder peakFinder_i (
        .clk       (clk),
        .rstN      (rstN),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanLast  (scanLast),
        .pixel     (pixel),
        .counts    (counts),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

`default_nettype wire

// ==== verification/histFsm_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module histFsmAssertions
    import histConfigPkg::*, histCtrlPkg::*;
(
    input logic                      clk,
    input logic                      rstN,
    input histState                  state,
    input logic                      wrEn,
    input logic                      dataValid,
    input logic [$clog2(acqNum)-1:0] acqCnt,
    input logic                      scanValid,
    input logic [binAddrWidth-1:0]   scanBin,
    input logic                      s2Valid,
    input logic                      rEnable,
    input logic [binAddrWidth-1:0]   raddr
);

    // assertion failures so far
    int failCount = 0;

    // window closes right after the last timestamp of a pixel
    lastAcqCloses: assert property (
        @(posedge clk) disable iff (!rstN)
        (wrEn && dataValid && acqCnt == acqNum - 1) |=> (!wrEn && state == stDrain)
    ) else begin
        failCount++;
        $error("input window still open after the last timestamp");
    end

    // scan zero-write and increment write share the write port
    scanNoIncrement: assert property (
        @(posedge clk) disable iff (!rstN)
        !(scanValid && s2Valid)
    ) else begin
        failCount++;
        $error("scanValid together with an increment write");
    end

    // scan data comes from the read issued scanLatency cycles before
    scanDataAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        scanValid |-> ($past(rEnable, scanLatency) && $past(raddr, scanLatency) == scanBin)
    ) else begin
        failCount++;
        $error("scanBin does not match the bin read for it");
    end

endmodule

bind histFsm histFsmAssertions fsmChecks_i (
    .clk       (clk),
    .rstN      (rstN),
    .state     (state),
    .wrEn      (wrEn),
    .dataValid (dataValid),
    .acqCnt    (acqCnt),
    .scanValid (scanValid),
    .scanBin   (scanBin),
    .s2Valid   (s2Valid),
    .rEnable   (rEnable),
    .raddr     (raddr)
);

`default_nettype wire

// ==== verification/histTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module histTb
    import histConfigPkg::*;
();

    localparam int clkPeriod = 40;
    localparam int rowNum = 8;
    localparam int maxCount = 2 ** countWidth - 1;
    // each pixel run covers gappy acquisition plus drain, scan and report
    localparam int timeoutCycles = rowNum * (acqNum * 4 + binNum * 2) + binNum + 8;

    typedef enum int {
        kindSplit,
        kindSame,
        kindRandom
    } patKind;

    logic                    clk;
    logic                    rstN;
    logic [dataWidth-1:0]    data;
    logic                    dataValid;
    logic                    wrEn;
    logic                    peakValid;
    logic [pixelWidth-1:0]   peakPixel;
    logic [binAddrWidth-1:0] peakBin;
    logic [countWidth-1:0]   peakCount;

    // one row per pixel run
    // split rows send the first tblSplit hits to bin A and the rest to bin B
    // random rows draw bins from A..B and leave the expected peak to the model (-1)
    patKind tblKind [rowNum];
    int     tblBinA [rowNum];
    int     tblBinB [rowNum];
    int     tblSplit [rowNum];
    bit     tblGaps [rowNum];
    int     tblExpBin [rowNum];
    int     tblExpCount [rowNum];

    // expected histogram of the current pixel
    int     hist [binNum];

    histTop dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .data      (data),
        .dataValid (dataValid),
        .wrEn      (wrEn),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: no complete run within %0d clock cycles", timeoutCycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // stop at the first bound assertion that fires
    initial begin
        wait (dut_i.fsm_i.fsmChecks_i.failCount != 0);
        $display("assertion failure in the state machine");
        $display("Simulation failed");
        $fatal(1, "assertion failure");
    end

    task automatic setRow(input int idx, input patKind kind, input int binA, input int binB,
                          input int split, input bit gaps, input int expBin,
                          input int expCount);
        tblKind[idx] = kind;
        tblBinA[idx] = binA;
        tblBinB[idx] = binB;
        tblSplit[idx] = split;
        tblGaps[idx] = gaps;
        tblExpBin[idx] = expBin;
        tblExpCount[idx] = expCount;
    endtask

    task automatic loadTable();
        // 14/10 split right after the clear phase
        setRow(0, kindSplit, 5, 40, 14, 1'b1, 5, 14);
        // back-to-back hits with bin B ending at exactly 15
        setRow(1, kindSplit, 33, 7, 9, 1'b0, 7, 15);
        // all in one bin so it saturates
        setRow(2, kindSame, 50, 0, acqNum, 1'b1, 50, maxCount);
        // 12/12 tie won by the lower index
        setRow(3, kindSplit, 60, 12, 12, 1'b1, 12, 12);
        // pixel index wraps here
        setRow(4, kindRandom, 8, 15, 0, 1'b1, -1, -1);
        setRow(5, kindSplit, 17, 2, 20, 1'b0, 17, maxCount);
        setRow(6, kindRandom, 0, binNum - 1, 0, 1'b1, -1, -1);
        setRow(7, kindRandom, 40, 47, 0, 1'b1, -1, -1);
    endtask

    function automatic int pickBin(input int row, input int idx);
        case (tblKind[row])
            kindSplit: return (idx < tblSplit[row]) ? tblBinA[row] : tblBinB[row];
            kindSame: return tblBinA[row];
            default: return tblBinA[row] + $urandom_range(tblBinB[row] - tblBinA[row]);
        endcase
    endfunction

    // saturating count as in the 4-bit bin counters
    task automatic addHit(input int bin);
        if (hist[bin] < maxCount) begin
            hist[bin]++;
        end
    endtask

    // lowest bin with the highest count or bin 0 when empty
    task automatic modelPeak(output int bin, output int count);
        bin = 0;
        count = 0;
        for (int b = 0; b < binNum; b++) begin
            if (hist[b] > count) begin
                bin = b;
                count = hist[b];
            end
        end
    endtask

    // holds one timestamp until the DUT takes it
    task automatic sendTimestamp(input int bin, input bit gaps);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (gaps && $urandom_range(3) == 0) begin
                // idle cycle
                dataValid = 1'b0;
                data = dataWidth'($urandom);
            end else begin
                dataValid = 1'b1;
                data = {binAddrWidth'(bin), (dataWidth - binAddrWidth)'($urandom)};
                // wrEn only moves on the rising edge so this is the value it will see
                if (wrEn) begin
                    addHit(bin);
                    taken = 1'b1;
                end
            end
        end
    endtask

    task automatic checkPixel(input logic [pixelWidth-1:0] expected,
                              input logic [pixelWidth-1:0] actual);
        if (actual !== expected) begin
            $display("ERR peakPixel expected 0x%h actual 0x%h", expected, actual);
            $display("Simulation failed");
            $fatal(1, "peakPixel mismatch");
        end
    endtask

    task automatic checkBin(input logic [binAddrWidth-1:0] expected,
                            input logic [binAddrWidth-1:0] actual);
        if (actual !== expected) begin
            $display("ERR peakBin expected 0x%h actual 0x%h", expected, actual);
            $display("Simulation failed");
            $fatal(1, "peakBin mismatch");
        end
    endtask

    task automatic checkCount(input logic [countWidth-1:0] expected,
                              input logic [countWidth-1:0] actual);
        if (actual !== expected) begin
            $display("ERR peakCount expected 0x%h actual 0x%h", expected, actual);
            $display("Simulation failed");
            $fatal(1, "peakCount mismatch");
        end
    endtask

    initial begin
        int expBin;
        int expCount;
        void'($urandom(32'h9d5eaf37));
        rstN = 1'b0;
        data = '0;
        dataValid = 1'b0;
        loadTable();
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        for (int row = 0; row < rowNum; row++) begin
            foreach (hist[b]) begin
                hist[b] = 0;
            end
            for (int i = 0; i < acqNum; i++) begin
                sendTimestamp(pickBin(row, i), tblGaps[row]);
            end
            // dataValid stays high and has to be ignored until the next window
            do begin
                @(negedge clk);
                if (wrEn) begin
                    $display("input window opened again before the peak result");
                    $display("Simulation failed");
                    $fatal(1, "early wrEn");
                end
                dataValid = 1'b1;
                data = dataWidth'($urandom);
            end while (!peakValid);

            modelPeak(expBin, expCount);
            if (tblExpBin[row] >= 0) begin
                expBin = tblExpBin[row];
                expCount = tblExpCount[row];
            end
            checkPixel(pixelWidth'(row % pixelNum), peakPixel);
            checkBin(binAddrWidth'(expBin), peakBin);
            checkCount(countWidth'(expCount), peakCount);
        end

        if (dut_i.fsm_i.fsmChecks_i.failCount != 0) begin
            $display("%0d assertion failures in the state machine",
                     dut_i.fsm_i.fsmChecks_i.failCount);
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/histConfigPkg.sv
rtl/histCtrlPkg.sv
rtl/binRam.sv
rtl/histFsm.sv
rtl/peakFinder.sv
rtl/histTop.sv
verification/histFsm_assertions.sv
verification/histTb.sv

// ==== Bender.yml ====
package:
  name: tof_hist

sources:
  # design
  - files:
      - rtl/histConfigPkg.sv
      - rtl/histCtrlPkg.sv
      - rtl/binRam.sv
      - rtl/histFsm.sv
      - rtl/peakFinder.sv
      - rtl/histTop.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - verification/histFsm_assertions.sv
      - verification/histTb.sv
